/* include/ooo_consts.svh */
`ifndef OOO_CONSTS_SVH
`define OOO_CONSTS_SVH

// datapath and register file
`define XLEN        32
`define NUM_REGS    32
`define REG_AW      5

// reorder buffer, depth is 2**TAG_W
`define ROB_DEPTH   8
`define TAG_W       3

// load cycle plus one quotient bit per cycle
`define DIV_CYCLES  33

// major opcodes
`define OPC_OP      7'b0110011
`define OPC_OP_IMM  7'b0010011

// funct7 values
`define F7_MULDIV   7'b0000001
`define F7_ALT      7'b0100000  // sub, sra, srai

`endif

/* hw/ooo_pkg.sv */
`include "ooo_consts.svh"

package ooo_pkg;

    typedef struct packed {
        logic [6:0]         funct7;
        logic [`REG_AW-1:0] rs2;
        logic [`REG_AW-1:0] rs1;
        logic [2:0]         funct3;
        logic [`REG_AW-1:0] rd;
        logic [6:0]         opcode;
    } r_view_t;

    typedef struct packed {
        logic [11:0]        imm12;
        logic [`REG_AW-1:0] rs1;
        logic [2:0]         funct3;
        logic [`REG_AW-1:0] rd;
        logic [6:0]         opcode;
    } i_view_t;

    // same word, register or immediate layout
    typedef union packed {
        r_view_t r;
        i_view_t i;
    } inst_u;

    typedef enum logic [1:0] {
        UNIT_ALU,
        UNIT_MUL,
        UNIT_DIV
    } unit_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    typedef struct packed {
        logic               valid;
        logic [`TAG_W-1:0]  tag;
        unit_e              unit;
        logic [3:0]         op;    // alu_op_e, or funct3 for mul/div
        logic [`XLEN-1:0]   a;
        logic [`XLEN-1:0]   b;
        logic [`REG_AW-1:0] rd;
    } uop_t;

    typedef struct packed {
        logic              valid;
        logic [`TAG_W-1:0] tag;
        logic [`XLEN-1:0]  value;
    } result_t;

    typedef struct packed {
        logic               valid;
        logic [`REG_AW-1:0] rd;
        logic [`XLEN-1:0]   value;
    } commit_t;

endpackage

/* hw/issue_decode.sv */
`timescale 1ns/1ns
`include "ooo_consts.svh"

module issue_decode import ooo_pkg::*; (
    input  logic               clk,
    input  logic               arst_n,
    input  inst_u              inst,
    input  logic               inst_valid,
    output logic               inst_ready,
    output logic [`REG_AW-1:0] rs1_addr,
    output logic [`REG_AW-1:0] rs2_addr,
    input  logic [`XLEN-1:0]   rs1_data,
    input  logic [`XLEN-1:0]   rs2_data,
    input  logic [`TAG_W-1:0]  alloc_tag,
    input  logic               rob_full,
    input  logic               div_busy,
    output logic               alloc,
    output logic [`REG_AW-1:0] alloc_rd,
    output uop_t               alu_uop,
    output uop_t               md_uop,
    input  commit_t            commit
);

    logic                 is_op;
    logic                 is_imm;
    logic                 is_md;
    logic                 is_div;
    logic                 hazard;
    logic                 fire;
    logic [`REG_AW-1:0]   dest;
    logic [`XLEN-1:0]     imm;
    logic [`NUM_REGS-1:0] busy;
    alu_op_e              alu_op;
    uop_t                 uop_d;
    uop_t                 uop_q;
    logic                 alu_vld_q;
    logic                 md_vld_q;

    assign is_op  = inst.r.opcode == `OPC_OP;
    assign is_imm = inst.i.opcode == `OPC_OP_IMM;
    assign is_md  = is_op && inst.r.funct7 == `F7_MULDIV;
    assign is_div = is_md && inst.r.funct3[2];
    assign dest   = (is_op || is_imm) ? inst.r.rd : '0;  // anything else retires to x0
    assign imm    = {{(`XLEN-12){inst.i.imm12[11]}}, inst.i.imm12};

    assign rs1_addr = inst.r.rs1;
    assign rs2_addr = inst.r.rs2;

    // busy[0] never sets, so x0 never stalls
    assign hazard = ((is_op || is_imm) && busy[inst.r.rs1])
                  || (is_op && busy[inst.r.rs2])
                  || busy[dest];

    assign inst_ready = !rob_full && !(inst_valid && (hazard || (is_div && div_busy)));
    assign fire       = inst_valid && inst_ready;
    assign alloc      = fire;
    assign alloc_rd   = dest;

    always_comb begin
        case (inst.r.funct3)
            3'b000:  alu_op = (is_op && inst.r.funct7 == `F7_ALT) ? ALU_SUB : ALU_ADD;
            3'b001:  alu_op = ALU_SLL;
            3'b010:  alu_op = ALU_SLT;
            3'b011:  alu_op = ALU_SLTU;
            3'b100:  alu_op = ALU_XOR;
            3'b101:  alu_op = (inst.r.funct7 == `F7_ALT) ? ALU_SRA : ALU_SRL; // srai too
            3'b110:  alu_op = ALU_OR;
            default: alu_op = ALU_AND;
        endcase
        if (!(is_op || is_imm)) begin
            alu_op = ALU_ADD;  // no-op, 0 + 0
        end
    end

    always_comb begin
        uop_d.valid = 1'b1;
        uop_d.tag   = alloc_tag;
        uop_d.unit  = is_md ? (is_div ? UNIT_DIV : UNIT_MUL) : UNIT_ALU;
        uop_d.op    = is_md ? {1'b0, inst.r.funct3} : alu_op;
        uop_d.a     = (is_op || is_imm) ? rs1_data : '0;
        uop_d.b     = is_op ? rs2_data : (is_imm ? imm : '0);
        uop_d.rd    = dest;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy      <= '0;
            alu_vld_q <= 1'b0;
            md_vld_q  <= 1'b0;
        end else begin
            if (commit.valid) begin
                busy[commit.rd] <= 1'b0;
            end
            if (fire && dest != '0) begin
                busy[dest] <= 1'b1;
            end
            alu_vld_q <= fire && !is_md;
            md_vld_q  <= fire && is_md;
        end
    end

    // one issue per cycle, so both units share the payload
    always_ff @(posedge clk) begin
        if (fire) begin
            uop_q <= uop_d;
        end
    end

    always_comb begin
        alu_uop       = uop_q;
        alu_uop.valid = alu_vld_q;
        md_uop        = uop_q;
        md_uop.valid  = md_vld_q;
    end

endmodule

/* hw/alu_unit.sv */
`timescale 1ns/1ns
`include "ooo_consts.svh"

module alu_unit import ooo_pkg::*; (
    input  logic    clk,
    input  logic    arst_n,
    input  uop_t    uop,
    output result_t res
);

    localparam int SH_W = $clog2(`XLEN);

    logic [`XLEN-1:0]  y;
    logic [SH_W-1:0]   sh;
    logic              vld_q;
    logic [`TAG_W-1:0] tag_q;
    logic [`XLEN-1:0]  val_q;

    assign sh = uop.b[SH_W-1:0];

    always_comb begin
        case (alu_op_e'(uop.op))
            ALU_ADD:  y = uop.a + uop.b;
            ALU_SUB:  y = uop.a - uop.b;
            ALU_SLL:  y = uop.a << sh;
            ALU_SLT:  y = {{(`XLEN-1){1'b0}}, $signed(uop.a) < $signed(uop.b)};
            ALU_SLTU: y = {{(`XLEN-1){1'b0}}, uop.a < uop.b};
            ALU_XOR:  y = uop.a ^ uop.b;
            ALU_SRL:  y = uop.a >> sh;
            ALU_SRA:  y = $signed(uop.a) >>> sh;
            ALU_OR:   y = uop.a | uop.b;
            ALU_AND:  y = uop.a & uop.b;
            default:  y = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            vld_q <= 1'b0;
        end else begin
            vld_q <= uop.valid;
        end
    end

    always_ff @(posedge clk) begin
        tag_q <= uop.tag;
        val_q <= y;
    end

    assign res = '{vld_q, tag_q, val_q};

endmodule

/* hw/mul_div_unit.sv */
`timescale 1ns/1ns
`include "ooo_consts.svh"

module mul_div_unit import ooo_pkg::*; (
    input  logic    clk,
    input  logic    arst_n,
    input  uop_t    uop,
    output result_t mul_res,
    output result_t div_res,
    output logic    div_busy
);

    localparam int CNT_W = $clog2(`DIV_CYCLES);

    logic                        mul_go;
    logic                        div_go;
    logic signed [`XLEN:0]       ma;
    logic signed [`XLEN:0]       mb;
    logic signed [2*`XLEN+1:0]   prod_d;
    logic [2*`XLEN-1:0]          prod_q;
    logic                        s1_vld_q;
    logic [`TAG_W-1:0]           s1_tag_q;
    logic                        s1_hi_q;
    logic                        s2_vld_q;
    logic [`TAG_W-1:0]           s2_tag_q;
    logic [`XLEN-1:0]            s2_val_q;
    logic                        dv_signed;
    logic                        a_neg;
    logic                        b_neg;
    logic [`XLEN:0]              shifted;
    logic [`XLEN:0]              diff;
    logic [`XLEN-1:0]            div_val;
    logic                        dv_run_q;
    logic                        dv_vld_q;
    logic [CNT_W-1:0]            dv_cnt_q;
    logic [`TAG_W-1:0]           dv_tag_q;
    logic                        dv_rem_sel_q;
    logic                        dv_neg_q_q;
    logic                        dv_neg_r_q;
    logic [`XLEN-1:0]            quo_q;
    logic [`XLEN-1:0]            rem_q;
    logic [`XLEN-1:0]            dsr_q;

    assign mul_go = uop.valid && uop.unit == UNIT_MUL;
    assign div_go = uop.valid && uop.unit == UNIT_DIV;

    // mul/mulh/mulhsu take a signed, mul/mulh take b signed
    assign ma     = {(uop.op[1:0] != 2'b11) && uop.a[`XLEN-1], uop.a};
    assign mb     = {!uop.op[1] && uop.b[`XLEN-1], uop.b};
    assign prod_d = ma * mb;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s1_vld_q <= 1'b0;
            s2_vld_q <= 1'b0;
        end else begin
            s1_vld_q <= mul_go;
            s2_vld_q <= s1_vld_q;
        end
    end

    always_ff @(posedge clk) begin
        prod_q   <= prod_d[2*`XLEN-1:0];
        s1_tag_q <= uop.tag;
        s1_hi_q  <= uop.op[1:0] != 2'b00;
        s2_tag_q <= s1_tag_q;
        s2_val_q <= s1_hi_q ? prod_q[2*`XLEN-1:`XLEN] : prod_q[`XLEN-1:0];
    end

    assign mul_res = '{s2_vld_q, s2_tag_q, s2_val_q};

    // restoring divide on magnitudes, signs fixed at the output
    assign dv_signed = !uop.op[0];  // div, rem
    assign a_neg     = dv_signed && uop.a[`XLEN-1];
    assign b_neg     = dv_signed && uop.b[`XLEN-1];
    assign shifted   = {rem_q, quo_q[`XLEN-1]};
    assign diff      = shifted - {1'b0, dsr_q};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dv_run_q <= 1'b0;
            dv_vld_q <= 1'b0;
            dv_cnt_q <= '0;
        end else begin
            dv_vld_q <= 1'b0;
            if (div_go) begin
                dv_run_q <= 1'b1;
                dv_cnt_q <= CNT_W'(`DIV_CYCLES - 1);
            end else if (dv_run_q) begin
                dv_cnt_q <= dv_cnt_q - 1'b1;
                if (dv_cnt_q == CNT_W'(1)) begin
                    dv_run_q <= 1'b0;
                    dv_vld_q <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (div_go) begin
            quo_q        <= a_neg ? -uop.a : uop.a;
            rem_q        <= '0;
            dsr_q        <= b_neg ? -uop.b : uop.b;
            dv_tag_q     <= uop.tag;
            dv_rem_sel_q <= uop.op[1];
            dv_neg_q_q   <= (a_neg ^ b_neg) && uop.b != '0;  // x/0 stays all ones
            dv_neg_r_q   <= a_neg;
        end else if (dv_run_q) begin
            if (!diff[`XLEN]) begin
                rem_q <= diff[`XLEN-1:0];
                quo_q <= {quo_q[`XLEN-2:0], 1'b1};
            end else begin
                rem_q <= shifted[`XLEN-1:0];
                quo_q <= {quo_q[`XLEN-2:0], 1'b0};
            end
        end
    end

    // min / -1 falls out of the magnitude path as min, rem 0
    assign div_val = dv_rem_sel_q ? (dv_neg_r_q ? -rem_q : rem_q)
                                  : (dv_neg_q_q ? -quo_q : quo_q);
    assign div_res = '{dv_vld_q, dv_tag_q, div_val};

    // also covers a divide sitting in the issue register
    assign div_busy = dv_run_q || div_go;

endmodule

/* hw/reorder_commit.sv */
`timescale 1ns/1ns
`include "ooo_consts.svh"

module reorder_commit import ooo_pkg::*; (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               alloc,
    output logic [`TAG_W-1:0]  alloc_tag,
    output logic               rob_full,
    input  logic [`REG_AW-1:0] rd_in,
    input  result_t            alu_res,
    input  result_t            mul_res,
    input  result_t            div_res,
    input  logic [`REG_AW-1:0] rs1_addr,
    input  logic [`REG_AW-1:0] rs2_addr,
    input  logic [`REG_AW-1:0] dbg_addr,
    output logic [`XLEN-1:0]   rs1_data,
    output logic [`XLEN-1:0]   rs2_data,
    output logic [`XLEN-1:0]   dbg_data,
    output commit_t            commit
);

    localparam int NUM_WB = 3;

    logic [`REG_AW-1:0]    ent_rd  [`ROB_DEPTH];
    logic [`XLEN-1:0]      ent_val [`ROB_DEPTH];
    logic [`ROB_DEPTH-1:0] ent_done;
    logic [`TAG_W-1:0]     head_q;
    logic [`TAG_W-1:0]     tail_q;
    logic [`TAG_W:0]       count_q;
    logic [`XLEN-1:0]      regs [`NUM_REGS];
    result_t               wb [NUM_WB];

    assign wb[0] = alu_res;
    assign wb[1] = mul_res;
    assign wb[2] = div_res;

    assign alloc_tag = tail_q;
    assign rob_full  = count_q == (`TAG_W+1)'(`ROB_DEPTH);

    // head retires as soon as its result is in
    assign commit = '{ent_done[head_q], ent_rd[head_q], ent_val[head_q]};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            head_q   <= '0;
            tail_q   <= '0;
            count_q  <= '0;
            ent_done <= '0;
        end else begin
            if (commit.valid) begin
                ent_done[head_q] <= 1'b0;
                head_q           <= head_q + 1'b1;
            end
            for (int i = 0; i < NUM_WB; i++) begin
                if (wb[i].valid) begin
                    ent_done[wb[i].tag] <= 1'b1;
                end
            end
            if (alloc) begin
                ent_done[tail_q] <= 1'b0;
                tail_q           <= tail_q + 1'b1;
            end
            count_q <= count_q + (`TAG_W+1)'(alloc) - (`TAG_W+1)'(commit.valid);
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            ent_rd[tail_q] <= rd_in;
        end
        for (int i = 0; i < NUM_WB; i++) begin
            if (wb[i].valid) begin
                ent_val[wb[i].tag] <= wb[i].value;
            end
        end
    end

    // architectural registers
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int r = 0; r < `NUM_REGS; r++) begin
                regs[r] <= '0;
            end
        end else if (commit.valid && commit.rd != '0) begin
            regs[commit.rd] <= commit.value;  // x0 stays zero
        end
    end

    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];
    assign dbg_data = regs[dbg_addr];

endmodule

/* hw/ooo_core.sv */
`timescale 1ns/1ns
`include "ooo_consts.svh"

module ooo_core import ooo_pkg::*; (
    input  logic               clk,
    input  logic               arst_n,
    input  inst_u              inst,
    input  logic               inst_valid,
    output logic               inst_ready,
    output commit_t            commit,
    input  logic [`REG_AW-1:0] dbg_addr,
    output logic [`XLEN-1:0]   dbg_data
);

    logic [`REG_AW-1:0] rs1_addr;
    logic [`REG_AW-1:0] rs2_addr;
    logic [`XLEN-1:0]   rs1_data;
    logic [`XLEN-1:0]   rs2_data;
    logic [`TAG_W-1:0]  alloc_tag;
    logic [`REG_AW-1:0] alloc_rd;
    logic               alloc;
    logic               rob_full;
    logic               div_busy;
    uop_t               alu_uop;
    uop_t               md_uop;
    result_t            alu_res;
    result_t            mul_res;
    result_t            div_res;

    issue_decode issue_decode_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .inst       (inst),
        .inst_valid (inst_valid),
        .inst_ready (inst_ready),
        .rs1_addr   (rs1_addr),
        .rs2_addr   (rs2_addr),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .alloc_tag  (alloc_tag),
        .rob_full   (rob_full),
        .div_busy   (div_busy),
        .alloc      (alloc),
        .alloc_rd   (alloc_rd),
        .alu_uop    (alu_uop),
        .md_uop     (md_uop),
        .commit     (commit)
    );

    alu_unit alu_unit_inst (
        .clk    (clk),
        .arst_n (arst_n),
        .uop    (alu_uop),
        .res    (alu_res)
    );

    mul_div_unit mul_div_unit_inst (
        .clk      (clk),
        .arst_n   (arst_n),
        .uop      (md_uop),
        .mul_res  (mul_res),
        .div_res  (div_res),
        .div_busy (div_busy)
    );

    reorder_commit reorder_commit_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .alloc     (alloc),
        .alloc_tag (alloc_tag),
        .rob_full  (rob_full),
        .rd_in     (alloc_rd),
        .alu_res   (alu_res),
        .mul_res   (mul_res),
        .div_res   (div_res),
        .rs1_addr  (rs1_addr),
        .rs2_addr  (rs2_addr),
        .dbg_addr  (dbg_addr),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .dbg_data  (dbg_data),
        .commit    (commit)
    );

endmodule

/* verification/ooo_core_properties.sv */
`timescale 1ns/1ns
`include "ooo_consts.svh"

module ooo_core_properties import ooo_pkg::*; (
    input logic    clk,
    input logic    arst_n,
    input inst_u   inst,
    input logic    inst_valid,
    input logic    inst_ready,
    input commit_t commit
);

    logic [`TAG_W:0] in_flight;  // accepted but not yet retired
    int              violations = 0;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            in_flight <= '0;
        end else begin
            in_flight <= in_flight + (`TAG_W+1)'(inst_valid && inst_ready)
                                   - (`TAG_W+1)'(commit.valid);
        end
    end

    reset_quiet: assert property (@(posedge clk) !arst_n |-> !commit.valid)
        else begin
            $error("commit valid while in reset");
            violations++;
        end

    commit_needs_entry: assert property (@(posedge clk) disable iff (!arst_n)
        commit.valid |-> in_flight != '0)
        else begin
            $error("commit with empty reorder buffer");
            violations++;
        end

    // stalled offer must hold
    offer_held: assert property (@(posedge clk) disable iff (!arst_n)
        inst_valid && !inst_ready |=> inst_valid && $stable(inst))
        else begin
            $error("instruction changed while stalled");
            violations++;
        end

endmodule

bind ooo_core ooo_core_properties ooo_core_properties_inst (
    .clk        (clk),
    .arst_n     (arst_n),
    .inst       (inst),
    .inst_valid (inst_valid),
    .inst_ready (inst_ready),
    .commit     (commit)
);

/* verification/ooo_core_tb.sv */
`timescale 1ns/1ns
`include "ooo_consts.svh"

module ooo_core_tb import ooo_pkg::*; ();

    localparam int GOLD_WORDS = 256;

    logic               clk;
    logic               arst_n;
    inst_u              inst;
    logic               inst_valid;
    logic               inst_ready;
    commit_t            commit;
    logic [`REG_AW-1:0] dbg_addr;
    logic [`XLEN-1:0]   dbg_data;

    logic [31:0] gold [GOLD_WORDS];
    logic [15:0] lfsr;
    int          num_inst;
    int          cycle_limit;
    int          cycles;
    int          commit_count;
    int          pass_count;
    int          fail_count;

    ooo_core ooo_core_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .inst       (inst),
        .inst_valid (inst_valid),
        .inst_ready (inst_ready),
        .commit     (commit),
        .dbg_addr   (dbg_addr),
        .dbg_data   (dbg_data)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("timeout after %0d cycles with %0d of %0d instructions committed",
                     cycles, commit_count, num_inst);
            $display("Test FAILED");
            $finish;
        end
    end

    // every retirement, extra ones included
    always @(negedge clk) begin
        if (arst_n === 1'b1 && commit.valid === 1'b1) begin
            commit_count = commit_count + 1;
        end
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic next_random_bit();
        logic fb;
        fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    task automatic compare_commit(input string name, input commit_t exp, input commit_t act);
        if (act !== exp) begin
            $display("FAILED %s expected rd x%0d value %h, actual valid %b rd x%0d value %h",
                     name, exp.rd, exp.value, act.valid, act.rd, act.value);
            fail_count++;
        end else begin
            $display("passed %s rd x%0d value %h", name, act.rd, act.value);
            pass_count++;
        end
    endtask

    task automatic compare_reg(input string name, input logic [`XLEN-1:0] exp,
                               input logic [`XLEN-1:0] act);
        if (act !== exp) begin
            $display("FAILED %s expected %h actual %h", name, exp, act);
            fail_count++;
        end else begin
            $display("passed %s value %h", name, act);
            pass_count++;
        end
    endtask

    task automatic drive_stream();
        logic [1:0] gap;
        for (int i = 0; i < num_inst; i++) begin
            gap[1] = next_random_bit();
            gap[0] = next_random_bit();
            if (gap != 2'd0) begin
                inst_valid <= 1'b0;
                repeat (gap) @(posedge clk);
            end
            inst       <= gold[1 + 3*i];
            inst_valid <= 1'b1;
            @(negedge clk);
            while (!inst_ready) begin
                @(negedge clk);
            end
            @(posedge clk);  // transfer edge
        end
        inst_valid <= 1'b0;
    endtask

    task automatic collect_commits();
        commit_t exp_c;
        for (int i = 0; i < num_inst; i++) begin
            exp_c.valid = 1'b1;
            exp_c.rd    = gold[2 + 3*i][`REG_AW-1:0];
            exp_c.value = gold[3 + 3*i];
            @(negedge clk);
            while (!commit.valid) begin
                @(negedge clk);
            end
            compare_commit($sformatf("commit %0d", i), exp_c, commit);
        end
    endtask

    task automatic check_registers();
        int base;
        base = 1 + 3*num_inst;
        for (int r = 0; r < `NUM_REGS; r++) begin
            @(posedge clk);
            dbg_addr <= `REG_AW'(r);
            @(negedge clk);
            compare_reg($sformatf("reg x%0d", r), gold[base + r], dbg_data);
        end
    endtask

    initial begin
        clk          = 1'b0;
        arst_n       = 1'b0;
        inst         = '0;
        inst_valid   = 1'b0;
        dbg_addr     = '0;
        lfsr         = 16'd99;
        cycles       = 0;
        commit_count = 0;
        pass_count   = 0;
        fail_count   = 0;
        $readmemh("verification/ooo_core_golden.txt", gold);
        num_inst    = int'(gold[0]);
        cycle_limit = num_inst * (`DIV_CYCLES + 4) + 200;  // worst case all divides

        repeat (3) @(posedge clk);
        arst_n <= 1'b1;

        fork
            drive_stream();
            collect_commits();
        join
        check_registers();

        if (commit_count != num_inst) begin
            $display("wrong number of commits, %0d seen for %0d instructions",
                     commit_count, num_inst);
            fail_count++;
        end
        if (ooo_core_inst.ooo_core_properties_inst.violations != 0) begin
            $display("%0d assertion failures were reported",
                     ooo_core_inst.ooo_core_properties_inst.violations);
            fail_count++;
        end
        $display("checks passed %0d failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* build.f */
+incdir+include
hw/ooo_pkg.sv
hw/issue_decode.sv
hw/alu_unit.sv
hw/mul_div_unit.sv
hw/reorder_commit.sv
hw/ooo_core.sv
verification/ooo_core_properties.sv
verification/ooo_core_tb.sv

/* Makefile */
SRCS := build.f $(wildcard include/*.svh hw/*.sv verification/*.sv)

.PHONY: run clean

run: obj_dir/Vooo_core_tb verification/ooo_core_golden.txt
	./obj_dir/Vooo_core_tb > sim.log 2>&1 || true
	cat sim.log
	grep -qx "Test OK" sim.log

obj_dir/Vooo_core_tb: $(SRCS)
	verilator --binary --assert --top-module ooo_core_tb -f build.f -o Vooo_core_tb

clean:
	rm -rf obj_dir sim.log

/* verification/ooo_core_golden.txt */
// first word is the instruction count, then per instruction: word, commit rd, commit value
// after the instructions come the final values of x0 to x31, eight per line
1e
06400093 01 00000064  // addi x1, x0, 100
ff900113 02 fffffff9  // addi x2, x0, -7
002081b3 03 0000005d  // add x3, x1, x2
40110233 04 ffffff95  // sub x4, x2, x1
00409293 05 00000640  // slli x5, x1, 4
40115313 06 fffffffc  // srai x6, x2, 1
01c15393 07 0000000f  // srli x7, x2, 28
0020b433 08 00000001  // sltu x8, x1, x2
fff14493 09 00000006  // xori x9, x2, -1
12345537 00 00000000  // lui, retires as no-op
02208533 0a fffffd44  // mul x10, x1, x2
021115b3 0b ffffffff  // mulh x11, x2, x1
02113633 0c 00000063  // mulhu x12, x2, x1
022126b3 0d fffffff9  // mulhsu x13, x2, x2
0220c733 0e fffffff2  // div x14, x1, x2
00500c13 18 00000005  // addi x24, x0, 5
02108cb3 19 00002710  // mul x25, x1, x1
0220e7b3 0f 00000002  // rem x15, x1, x2
018c8d33 1a 00002715  // add x26, x25, x24
02115833 10 028f5c28  // divu x16, x2, x1
021178b3 11 00000059  // remu x17, x2, x1
0200c933 12 ffffffff  // div x18, x1, x0
020179b3 13 fffffff9  // remu x19, x2, x0
00100a13 14 00000001  // addi x20, x0, 1
01fa1a13 14 80000000  // slli x20, x20, 31
fff00b13 16 ffffffff  // addi x22, x0, -1
036a4ab3 15 80000000  // div x21, x20, x22
036a6bb3 17 00000000  // rem x23, x20, x22
03708013 00 0000009b  // addi x0, x1, 55
00117db3 1b 00000060  // and x27, x2, x1
00000000 00000064 fffffff9 0000005d ffffff95 00000640 fffffffc 0000000f
00000001 00000006 fffffd44 ffffffff 00000063 fffffff9 fffffff2 00000002
028f5c28 00000059 ffffffff fffffff9 80000000 80000000 ffffffff 00000000
00000005 00002710 00002715 00000060 00000000 00000000 00000000 00000000
